// File: rtl/muldiv_consts.svh
// Width and divider step constants for the multiply/divide unit
// MULDIV_ITERS must equal MULDIV_WIDTH and MULDIV_CNT_WIDTH must count to it

`ifndef MULDIV_CONSTS_SVH
`define MULDIV_CONSTS_SVH

// Operand and result width in bits
`define MULDIV_WIDTH 16

// One shift-subtract step per quotient bit
`define MULDIV_ITERS `MULDIV_WIDTH

`define MULDIV_CNT_WIDTH 5

`endif

// File: rtl/muldiv_pkg.sv
// Shared types for the multiply/divide unit
// Words are plain vectors and are read as two's complement where signed

`include "muldiv_consts.svh"

package muldiv_pkg;

  // One operand or result
  typedef logic [`MULDIV_WIDTH-1:0] word_t;

  // Divider step counter
  typedef logic [`MULDIV_CNT_WIDTH-1:0] count_t;

  // Divider sequencing
  typedef enum logic {
    DIV_IDLE,
    DIV_RUN
  } div_state_t;

endpackage

// File: rtl/mult_pipe.sv
// Two-stage signed multiplier, returns the low word of the product
// Operands must stay stable while go is high; mult_done follows go after 2 cycles
// The high product word is discarded, so overflow wraps

`timescale 1ns/1ps

`include "muldiv_consts.svh"

module mult_pipe (
  input  logic              clk,
  input  logic              reset,
  input  logic              go,
  input  muldiv_pkg::word_t left,
  input  muldiv_pkg::word_t right,
  output muldiv_pkg::word_t mult_product,
  output logic              mult_done
);

  muldiv_pkg::word_t ltmp;
  muldiv_pkg::word_t rtmp;
  logic signed [2*`MULDIV_WIDTH-1:0] full_product;
  logic [1:0] done_sr;

  // First stage, operand registers
  always_ff @(posedge clk) begin
    if (reset || !go) begin
      ltmp <= '0;
      rtmp <= '0;
    end else begin
      ltmp <= left;
      rtmp <= right;
    end
  end

  // Both factors are signed, so they extend by sign to the double width
  assign full_product = $signed(ltmp) * $signed(rtmp);

  // Second stage
  always_ff @(posedge clk) begin
    if (go) begin
      mult_product <= full_product[`MULDIV_WIDTH-1:0];
    end
  end

  // Walks one bit per stage, so done lines up with the product register
  always_ff @(posedge clk) begin
    if (reset || !go) begin
      done_sr <= 2'b00;
    end else begin
      done_sr <= {done_sr[0], 1'b1};
    end
  end

  assign mult_done = done_sr[1];

endmodule

// File: rtl/div_iter.sv
// Signed divider built on a restoring shift-subtract loop over magnitudes
// Quotient truncates toward zero; remainder takes the sign of the divisor
// A zero divisor is not supported
// Starts only on a rising go; a zero dividend finishes in one cycle

`timescale 1ns/1ps

`include "muldiv_consts.svh"

module div_iter (
  input  logic              clk,
  input  logic              reset,
  input  logic              go,
  input  muldiv_pkg::word_t left,
  input  muldiv_pkg::word_t right,
  output muldiv_pkg::word_t div_quotient,
  output muldiv_pkg::word_t div_remainder,
  output logic              div_done
);

  muldiv_pkg::div_state_t state;
  muldiv_pkg::count_t     step_cnt;
  logic                   go_q;
  logic                   start;
  logic                   left_zero;
  logic                   last_step;

  muldiv_pkg::word_t left_mag;
  muldiv_pkg::word_t right_mag;

  // Values latched at start
  logic              left_sign;
  logic              right_sign;
  muldiv_pkg::word_t divisor_mag;

  // Partial remainder and dividend/quotient shift register
  muldiv_pkg::word_t rem_q;
  muldiv_pkg::word_t quo_q;

  logic [`MULDIV_WIDTH:0] partial;
  logic [`MULDIV_WIDTH:0] diff;
  logic                   take;
  muldiv_pkg::word_t      rem_next;

  logic              diff_signs;
  muldiv_pkg::word_t rem_adj;

  // The most negative value maps to itself, which reads correctly as unsigned
  assign left_mag  = left[`MULDIV_WIDTH-1] ? -left : left;
  assign right_mag = right[`MULDIV_WIDTH-1] ? -right : right;

  assign start     = go && !go_q && (state == muldiv_pkg::DIV_IDLE);
  assign left_zero = (left == '0);
  assign last_step = (step_cnt == muldiv_pkg::count_t'(`MULDIV_ITERS - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      go_q <= 1'b0;
    end else begin
      go_q <= go;
    end
  end

  // Sequencer
  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= muldiv_pkg::DIV_IDLE;
      step_cnt <= '0;
      div_done <= 1'b0;
    end else begin
      div_done <= 1'b0;
      case (state)
        muldiv_pkg::DIV_IDLE: begin
          if (start) begin
            step_cnt <= '0;
            // Nothing to shift for a zero dividend
            if (left_zero) begin
              div_done <= 1'b1;
            end else begin
              state <= muldiv_pkg::DIV_RUN;
            end
          end
        end
        muldiv_pkg::DIV_RUN: begin
          step_cnt <= step_cnt + 1'b1;
          if (last_step) begin
            div_done <= 1'b1;
            state    <= muldiv_pkg::DIV_IDLE;
          end
        end
        default: state <= muldiv_pkg::DIV_IDLE;
      endcase
    end
  end

  // One restoring step: bring down the next dividend bit and try a subtract
  assign partial  = {rem_q, quo_q[`MULDIV_WIDTH-1]};
  assign diff     = partial - {1'b0, divisor_mag};
  assign take     = (partial >= {1'b0, divisor_mag});
  assign rem_next = take ? diff[`MULDIV_WIDTH-1:0] : partial[`MULDIV_WIDTH-1:0];

  always_ff @(posedge clk) begin
    if (start) begin
      left_sign   <= left[`MULDIV_WIDTH-1];
      right_sign  <= right[`MULDIV_WIDTH-1];
      divisor_mag <= right_mag;
      rem_q       <= '0;
      quo_q       <= left_mag;
    end else if (state == muldiv_pkg::DIV_RUN) begin
      rem_q <= rem_next;
      quo_q <= {quo_q[`MULDIV_WIDTH-2:0], take};
    end
  end

  // Sign correction of the magnitude results
  assign diff_signs   = left_sign ^ right_sign;
  assign div_quotient = diff_signs ? -quo_q : quo_q;

  // Fold a nonzero remainder to the divisor side, then give it the divisor sign
  assign rem_adj       = (diff_signs && (|rem_q)) ? divisor_mag - rem_q : rem_q;
  assign div_remainder = right_sign ? -rem_adj : rem_adj;

endmodule

// File: rtl/result_join.sv
// Joins the multiplier and divider results into one done pulse
// Each result is captured once per operation; outputs only change with done
// Held flags clear while go is low, so go must stay high until done

`timescale 1ns/1ps

module result_join (
  input  logic              clk,
  input  logic              reset,
  input  logic              go,
  input  muldiv_pkg::word_t mult_product,
  input  logic              mult_done,
  input  muldiv_pkg::word_t div_quotient,
  input  muldiv_pkg::word_t div_remainder,
  input  logic              div_done,
  output muldiv_pkg::word_t product,
  output muldiv_pkg::word_t quotient,
  output muldiv_pkg::word_t remainder,
  output logic              done
);

  logic prod_held;
  logic div_held;
  logic prod_take;
  logic fire;

  muldiv_pkg::word_t prod_hold;
  muldiv_pkg::word_t quo_hold;
  muldiv_pkg::word_t rem_hold;

  // mult_done stays high with go, so only its first cycle counts
  assign prod_take = mult_done && !prod_held;
  assign fire      = go && prod_held && div_held;

  always_ff @(posedge clk) begin
    if (reset) begin
      prod_held <= 1'b0;
      div_held  <= 1'b0;
      done      <= 1'b0;
    end else begin
      done <= fire;
      if (!go || fire) begin
        prod_held <= 1'b0;
        div_held  <= 1'b0;
      end else begin
        if (prod_take) begin
          prod_held <= 1'b1;
        end
        if (div_done) begin
          div_held <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (prod_take) begin
      prod_hold <= mult_product;
    end
    if (div_done) begin
      quo_hold <= div_quotient;
      rem_hold <= div_remainder;
    end
  end

  // Outputs move together with done and hold until the next one
  always_ff @(posedge clk) begin
    if (reset) begin
      product   <= '0;
      quotient  <= '0;
      remainder <= '0;
    end else if (fire) begin
      product   <= prod_hold;
      quotient  <= quo_hold;
      remainder <= rem_hold;
    end
  end

endmodule

// File: rtl/muldiv_unit.sv
// Signed multiply and divide on one operand pair, finished by a single done
// Hold go high with stable operands until done, then drop it for a cycle
// A zero divisor is not supported

`timescale 1ns/1ps

module muldiv_unit (
  input  logic              clk,
  input  logic              reset,
  input  logic              go,
  input  muldiv_pkg::word_t left,
  input  muldiv_pkg::word_t right,
  output muldiv_pkg::word_t product,
  output muldiv_pkg::word_t quotient,
  output muldiv_pkg::word_t remainder,
  output logic              done
);

  muldiv_pkg::word_t mult_product;
  logic              mult_done;
  muldiv_pkg::word_t div_quotient;
  muldiv_pkg::word_t div_remainder;
  logic              div_done;

  // Both engines see the same go and operands and run side by side
  mult_pipe u_mult (
    .clk          (clk),
    .reset        (reset),
    .go           (go),
    .left         (left),
    .right        (right),
    .mult_product (mult_product),
    .mult_done    (mult_done)
  );

  div_iter u_div (
    .clk           (clk),
    .reset         (reset),
    .go            (go),
    .left          (left),
    .right         (right),
    .div_quotient  (div_quotient),
    .div_remainder (div_remainder),
    .div_done      (div_done)
  );

  result_join u_join (
    .clk           (clk),
    .reset         (reset),
    .go            (go),
    .mult_product  (mult_product),
    .mult_done     (mult_done),
    .div_quotient  (div_quotient),
    .div_remainder (div_remainder),
    .div_done      (div_done),
    .product       (product),
    .quotient      (quotient),
    .remainder     (remainder),
    .done          (done)
  );

endmodule

// File: dv/clk_gen.sv
// Free-running 10 ns clock and a synchronous reset
// Reset is held for the first 2 rising edges and drops 1 ns after the second

`timescale 1ns/1ps

module clk_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clk);
    #1 reset = 1'b0;
  end

endmodule

// File: dv/muldiv_assertions.sv
// Protocol assertions for muldiv_unit, attached with bind
// Assumes the go/done handshake and a divisor that is never zero while go is high

`timescale 1ns/1ps

module muldiv_assertions (
  input logic                   clk,
  input logic                   reset,
  input logic                   go,
  input muldiv_pkg::word_t      right,
  input logic                   done,
  input muldiv_pkg::div_state_t div_state
);

  // done is a single-cycle pulse
  done_one_cycle: assert property (
    @(posedge clk) disable iff (reset) done |=> !done
  ) else $error("done was high in two consecutive cycles");

  // Zero divisor is outside the supported range
  no_zero_divisor: assert property (
    @(posedge clk) disable iff (reset) go |-> (right != '0)
  ) else $error("go was high with a zero divisor");

  done_needs_go: assert property (
    @(posedge clk) disable iff (reset) $rose(done) |-> go
  ) else $error("done rose without go being high");

  // Clean state right after reset
  idle_after_reset: assert property (
    @(posedge clk) reset |=> (!done && (div_state == muldiv_pkg::DIV_IDLE))
  ) else $error("done high or divider busy after reset");

endmodule

// File: dv/muldiv_tb.sv
// Testbench for muldiv_unit
// Reads dv/muldiv_cases.txt relative to the project root, then runs LFSR cases
// Stops at the first mismatch or timeout

`timescale 1ns/1ps

`include "muldiv_consts.svh"

module muldiv_tb;

  localparam int    DONE_TIMEOUT  = 64;
  localparam int    RESET_TIMEOUT = 16;
  localparam int    RANDOM_CASES  = 200;
  localparam string CASES_FILE    = "dv/muldiv_cases.txt";

  logic              clk;
  logic              reset;
  logic              go;
  muldiv_pkg::word_t left;
  muldiv_pkg::word_t right;
  muldiv_pkg::word_t product;
  muldiv_pkg::word_t quotient;
  muldiv_pkg::word_t remainder;
  logic              done;

  // Results of the last done, which the outputs must keep
  muldiv_pkg::word_t held_product;
  muldiv_pkg::word_t held_quotient;
  muldiv_pkg::word_t held_remainder;

  logic [31:0] lfsr;
  int          case_count;

  clk_gen u_clk_gen (
    .clk   (clk),
    .reset (reset)
  );

  muldiv_unit i_muldiv_unit (
    .clk       (clk),
    .reset     (reset),
    .go        (go),
    .left      (left),
    .right     (right),
    .product   (product),
    .quotient  (quotient),
    .remainder (remainder),
    .done      (done)
  );

  bind muldiv_unit muldiv_assertions u_assertions (
    .clk       (clk),
    .reset     (reset),
    .go        (go),
    .right     (right),
    .done      (done),
    .div_state (u_div.state)
  );

  task automatic abort_run();
    $display("tests failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_word(input string name, input muldiv_pkg::word_t got,
                            input muldiv_pkg::word_t expected);
    if (got !== expected) begin
      $display("CHECK FAILED %s got 0x%h expected 0x%h in case %0d",
               name, got, expected, case_count);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      $display("CHECK FAILED %s got 0x%h expected 0x%h in case %0d",
               name, got, expected, case_count);
      abort_run();
    end
  endtask

  task automatic check_outputs(input muldiv_pkg::word_t exp_product,
                               input muldiv_pkg::word_t exp_quotient,
                               input muldiv_pkg::word_t exp_remainder);
    check_word("product", product, exp_product);
    check_word("quotient", quotient, exp_quotient);
    check_word("remainder", remainder, exp_remainder);
  endtask

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic draw_word(output muldiv_pkg::word_t w);
    for (int i = 0; i < `MULDIV_WIDTH; i++) begin
      lfsr = lfsr_next(lfsr);
      w[i] = lfsr[31];
    end
  endtask

  // Integer division truncates toward zero
  // The remainder is the floored modulo, so it carries the divisor sign
  task automatic model_results(input muldiv_pkg::word_t l, input muldiv_pkg::word_t r,
                               output muldiv_pkg::word_t p, output muldiv_pkg::word_t q,
                               output muldiv_pkg::word_t rm);
    longint lv;
    longint rv;
    longint m;
    lv = longint'($signed(l));
    rv = longint'($signed(r));
    p = muldiv_pkg::word_t'(lv * rv);
    q = muldiv_pkg::word_t'(lv / rv);
    m = lv % rv;
    if ((m != 0) && ((m < 0) != (rv < 0))) begin
      m = m + rv;
    end
    rm = muldiv_pkg::word_t'(m);
  endtask

  task automatic wait_reset_release();
    int waited;
    waited = 0;
    @(posedge clk);
    while (reset) begin
      @(posedge clk);
      waited++;
      if (waited > RESET_TIMEOUT) begin
        $display("Reset was never released");
        abort_run();
      end
    end
    #1;
  endtask

  // Entered 1 ns after an edge with go low for at least one cycle
  task automatic run_case(input muldiv_pkg::word_t l, input muldiv_pkg::word_t r,
                          input muldiv_pkg::word_t exp_product,
                          input muldiv_pkg::word_t exp_quotient,
                          input muldiv_pkg::word_t exp_remainder);
    int waited;
    case_count++;
    go     = 1'b1;
    left   = l;
    right  = r;
    waited = 0;
    do begin
      @(posedge clk);
      #1;
      waited++;
      if (!done) begin
        if (waited >= DONE_TIMEOUT) begin
          $display("Timed out after %0d cycles waiting for done in case %0d",
                   DONE_TIMEOUT, case_count);
          abort_run();
        end
        // Old results stay until the new done
        check_outputs(held_product, held_quotient, held_remainder);
      end
    end while (!done);
    check_outputs(exp_product, exp_quotient, exp_remainder);
    held_product   = exp_product;
    held_quotient  = exp_quotient;
    held_remainder = exp_remainder;
    @(posedge clk);
    #1;
    check_bit("done", done, 1'b0);
    check_outputs(held_product, held_quotient, held_remainder);
    go = 1'b0;
    @(posedge clk);
    #1;
    check_bit("done", done, 1'b0);
  endtask

  task automatic run_file_cases();
    int                fd;
    int                n;
    int                line_no;
    int                file_cases;
    string             line;
    muldiv_pkg::word_t l;
    muldiv_pkg::word_t r;
    muldiv_pkg::word_t p;
    muldiv_pkg::word_t q;
    muldiv_pkg::word_t rm;
    fd = $fopen(CASES_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the cases file %s", CASES_FILE);
      abort_run();
    end
    line_no    = 0;
    file_cases = 0;
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      line_no++;
      if (n == 0 || line.len() == 0) continue;
      if (line[0] == "#" || line[0] == "\n" || line[0] == "\r") continue;
      n = $sscanf(line, "%h %h %h %h %h", l, r, p, q, rm);
      if (n != 5) begin
        $display("Line %0d of the cases file does not hold five hex values", line_no);
        abort_run();
      end
      run_case(l, r, p, q, rm);
      file_cases++;
    end
    $fclose(fd);
    if (file_cases == 0) begin
      $display("The cases file holds no cases");
      abort_run();
    end
  endtask

  initial begin
    muldiv_pkg::word_t l;
    muldiv_pkg::word_t r;
    muldiv_pkg::word_t p;
    muldiv_pkg::word_t q;
    muldiv_pkg::word_t rm;
    go             = 1'b0;
    left           = '0;
    right          = muldiv_pkg::word_t'(1);
    held_product   = '0;
    held_quotient  = '0;
    held_remainder = '0;
    lfsr           = 32'h447e;
    case_count     = 0;

    wait_reset_release();
    check_bit("done", done, 1'b0);
    check_outputs(held_product, held_quotient, held_remainder);

    run_file_cases();

    for (int i = 0; i < RANDOM_CASES; i++) begin
      draw_word(l);
      draw_word(r);
      if (r == '0) r = muldiv_pkg::word_t'(1);
      model_results(l, r, p, q, rm);
      run_case(l, r, p, q, rm);
    end

    $display("Ran %0d cases", case_count);
    $display("all tests passed");
    $finish;
  end

endmodule

// File: dv/muldiv_cases.txt
# Each line holds left, right, product, quotient and remainder
# Values are 16-bit hex in two's complement
0000 0001 0000 0000 0000
0000 fffb 0000 0000 0000
0007 0002 000e 0003 0001
fff9 0002 fff2 fffd 0001
0007 fffe fff2 fffd ffff
fff9 fffe 000e 0003 ffff
0064 0007 02bc 000e 0002
ff9c 0007 fd44 fff2 0005
0064 fff9 fd44 fff2 fffb
ff9c fff9 02bc 000e fffe
000c 0004 0030 0003 0000
fff4 0004 ffd0 fffd 0000
000c fffc ffd0 fffd 0000
8000 ffff 8000 8000 0000
8000 0001 8000 8000 0000
7fff 7fff 0001 0001 0000
7fff 0002 fffe 3fff 0001
8000 8000 0000 0001 0000
0005 8000 8000 0000 8005
0003 0007 0015 0000 0003
fffd 0007 ffeb 0000 0004
1234 0010 2340 0123 0004
1234 5678 0060 0000 1234
abcd 0123 4a07 ffb6 010e
4000 0003 c000 1555 0001
ff00 ff00 0000 0001 0000
00ff fff0 f010 fff1 ffff
0001 ffff ffff ffff 0000
ffff ffff 0001 0001 0000
7fff 8000 8000 0000 ffff
03e8 0003 0bb8 014d 0001
fc18 0003 f448 feb3 0002
0064 0064 2710 0001 0000
2000 0008 0000 0400 0000
0009 fffd ffe5 fffd 0000

// File: tb.f
+incdir+rtl
rtl/muldiv_pkg.sv
rtl/mult_pipe.sv
rtl/div_iter.sv
rtl/result_join.sv
rtl/muldiv_unit.sv
dv/clk_gen.sv
dv/muldiv_assertions.sv
dv/muldiv_tb.sv

// File: Makefile
# Verilator build and run for the muldiv testbench
# Run from the project root, the testbench reads dv/muldiv_cases.txt from there

VERILATOR ?= verilator
TOP       ?= muldiv_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= tests failed
VFLAGS    ?= --timing --assert

BIN := $(BUILD_DIR)/V$(TOP)
SRCS := $(wildcard rtl/*.sv rtl/*.svh dv/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BIN)
	@$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi; \
	echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
